/* rtl/sdram_config.svh */
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// host address split, top bits first
`define SDRAM_ROW_W       12
`define SDRAM_BANK_W      2
`define SDRAM_COL_W       13

// width of the address pins
`define SDRAM_PIN_ADDR_W  13

// request queue entries, power of two
`define SDRAM_FIFO_DEPTH  4

// least cycles from a command to the next one
`define SDRAM_GAP_ACTV    2
`define SDRAM_GAP_ARSR    15  // longest gap, sizes the timer
`define SDRAM_GAP_DEFAULT 3

`endif

/* rtl/sdram_cmd_pkg.sv */
`include "sdram_config.svh"

package sdram_cmd_pkg;

  // opcodes driven on the command pins
  typedef enum logic [2:0] {
    NOOP = 3'd0,
    ACTV = 3'd1,
    READ = 3'd2,
    WRTE = 3'd3,
    PRCH = 3'd4,
    ARSR = 3'd5
  } cmd_op_t;

  typedef logic [`SDRAM_ROW_W-1:0]      row_t;
  typedef logic [`SDRAM_BANK_W-1:0]     bank_t;
  typedef logic [`SDRAM_PIN_ADDR_W-1:0] pin_addr_t;

  // one word on the command pins
  typedef struct packed {
    cmd_op_t   op;
    bank_t     bank;
    pin_addr_t addr;
  } cmd_word_t;

  typedef enum logic {
    IDLE = 1'b0,  // waiting to pick a series
    RUN  = 1'b1   // issuing the loaded series
  } seq_state_t;

endpackage

/* rtl/host_req_pkg.sv */
`include "sdram_config.svh"

package host_req_pkg;

  // row | bank | column, from msb down
  typedef logic [`SDRAM_ROW_W+`SDRAM_BANK_W+`SDRAM_COL_W-1:0] host_addr_t;

  typedef struct packed {
    host_addr_t addr;
    logic       we;   // write when set
  } host_req_t;

endpackage

/* rtl/req_fifo.sv */
`timescale 1ns/1ps
`include "sdram_config.svh"

module req_fifo
(
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    push,
  input  host_req_pkg::host_req_t req,
  input  logic                    pop,
  output logic                    full,
  output logic                    has_req,
  output host_req_pkg::host_req_t head
);

  localparam int DEPTH = `SDRAM_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  host_req_pkg::host_req_t mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;
  logic                    do_push;
  logic                    do_pop;

  assign full    = (count == (PTR_W+1)'(DEPTH));
  assign has_req = (count != '0);
  assign head    = mem[rd_ptr];  // oldest entry

  assign do_push = push && !full;  // push while full is lost
  assign do_pop  = pop && has_req;

  always_ff @(posedge CLK)
  begin
    if (do_push)
      mem[wr_ptr] <= req;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* rtl/bank_timer.sv */
`timescale 1ns/1ps
`include "sdram_config.svh"

module bank_timer
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   issue,
  input  sdram_cmd_pkg::cmd_op_t op,
  output logic                   ready
);

  // refresh has the longest gap
  localparam int CNT_W = $clog2(`SDRAM_GAP_ARSR + 1);

  logic [CNT_W-1:0]       cnt;      // cycles still to wait
  logic [CNT_W-1:0]       gap;
  sdram_cmd_pkg::cmd_op_t last_op;
  logic                   last_rw;  // last issue was a read or write

  // load one less, the issue cycle counts
  always_comb
  begin
    case (op)
      sdram_cmd_pkg::ACTV: gap = CNT_W'(`SDRAM_GAP_ACTV - 1);
      sdram_cmd_pkg::ARSR: gap = CNT_W'(`SDRAM_GAP_ARSR - 1);
      default:             gap = CNT_W'(`SDRAM_GAP_DEFAULT - 1);
    endcase
  end

  // same read or write may follow at once
  assign ready = (cnt == '0) || (last_rw && (op == last_op));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cnt     <= '0;  // already expired
      last_op <= sdram_cmd_pkg::NOOP;
      last_rw <= 1'b0;
    end
    else
    begin
      if (issue)
      begin
        cnt     <= gap;
        last_op <= op;
        last_rw <= (op == sdram_cmd_pkg::READ) || (op == sdram_cmd_pkg::WRTE);
      end
      else if (cnt != '0)
      begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

/* rtl/cmd_sequencer.sv */
`timescale 1ns/1ps
`include "sdram_config.svh"

module cmd_sequencer
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     has_req,
  input  host_req_pkg::host_req_t  head,
  input  logic                     ref_toggle,
  input  logic                     ready,
  output logic                     pop,
  output sdram_cmd_pkg::cmd_op_t   next_op,
  output logic                     issue,
  output sdram_cmd_pkg::cmd_word_t cmd,
  output logic                     cmd_latched,
  output logic                     page_active
);

  localparam int BANK_LSB = `SDRAM_COL_W;
  localparam int ROW_LSB  = `SDRAM_COL_W + `SDRAM_BANK_W;

  localparam sdram_cmd_pkg::pin_addr_t PRCH_ALL = 'h400;  // a10 set, all banks
  localparam sdram_cmd_pkg::cmd_word_t NOP_WORD = '{op: sdram_cmd_pkg::NOOP,
                                                    bank: '0,
                                                    addr: '0};

  sdram_cmd_pkg::seq_state_t state;
  sdram_cmd_pkg::cmd_op_t    ser [3];   // ser[0] goes out next
  logic [1:0]                steps;     // commands left in series
  host_req_pkg::host_req_t   req_q;
  sdram_cmd_pkg::row_t       open_row;
  sdram_cmd_pkg::bank_t      open_bank;
  logic                      ref_ack;
  logic                      ref_pend;
  sdram_cmd_pkg::row_t       head_row;
  sdram_cmd_pkg::bank_t      head_bank;
  sdram_cmd_pkg::cmd_op_t    head_rw;
  logic                      hit;
  sdram_cmd_pkg::row_t       req_row;
  sdram_cmd_pkg::bank_t      req_bank;
  sdram_cmd_pkg::pin_addr_t  req_col;
  sdram_cmd_pkg::cmd_word_t  word;

  assign ref_pend = ref_ack ^ ref_toggle;  // any edge on the toggle

  assign head_row  = head.addr[ROW_LSB +: `SDRAM_ROW_W];
  assign head_bank = head.addr[BANK_LSB +: `SDRAM_BANK_W];
  assign head_rw   = head.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
  assign hit       = page_active && (head_row == open_row) && (head_bank == open_bank);

  assign req_row  = req_q.addr[ROW_LSB +: `SDRAM_ROW_W];
  assign req_bank = req_q.addr[BANK_LSB +: `SDRAM_BANK_W];
  assign req_col  = req_q.addr[0 +: `SDRAM_COL_W];

  // refresh takes priority over the queue
  assign pop     = (state == sdram_cmd_pkg::IDLE) && !ref_pend && has_req;
  assign next_op = ser[0];
  assign issue   = (state == sdram_cmd_pkg::RUN) && ready;

  always_comb
  begin
    word    = NOP_WORD;
    word.op = ser[0];
    case (ser[0])
      sdram_cmd_pkg::ACTV:
      begin
        word.bank = req_bank;
        word.addr = {req_row[11:10], 1'b0, req_row[9:0]};  // keep a10 clear
      end
      sdram_cmd_pkg::PRCH:
        word.addr = PRCH_ALL;
      sdram_cmd_pkg::READ,
      sdram_cmd_pkg::WRTE:
      begin
        word.bank = req_bank;
        word.addr = req_col;
      end
      default:
        word.addr = '0;  // refresh carries no address
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state       <= sdram_cmd_pkg::IDLE;
      ser         <= '{sdram_cmd_pkg::NOOP, sdram_cmd_pkg::NOOP, sdram_cmd_pkg::NOOP};
      steps       <= 2'd0;
      ref_ack     <= ref_toggle;  // no refresh owed out of reset
      cmd         <= NOP_WORD;
      cmd_latched <= 1'b0;
      page_active <= 1'b0;
    end
    else
    begin
      cmd         <= NOP_WORD;
      cmd_latched <= 1'b0;
      case (state)
        sdram_cmd_pkg::IDLE:
        begin
          if (ref_pend)
          begin
            ref_ack <= ref_toggle;
            ser     <= '{sdram_cmd_pkg::PRCH, sdram_cmd_pkg::ARSR, sdram_cmd_pkg::NOOP};
            steps   <= 2'd2;
            state   <= sdram_cmd_pkg::RUN;
          end
          else if (has_req)
          begin
            if (hit)
            begin
              ser   <= '{head_rw, sdram_cmd_pkg::NOOP, sdram_cmd_pkg::NOOP};
              steps <= 2'd1;
            end
            else
            begin
              ser   <= '{sdram_cmd_pkg::PRCH, sdram_cmd_pkg::ACTV, head_rw};
              steps <= 2'd3;
            end
            state <= sdram_cmd_pkg::RUN;
          end
        end
        sdram_cmd_pkg::RUN:
        begin
          if (issue)
          begin
            cmd         <= word;
            cmd_latched <= (ser[0] == sdram_cmd_pkg::READ) || (ser[0] == sdram_cmd_pkg::WRTE);
            ser         <= '{ser[1], ser[2], sdram_cmd_pkg::NOOP};
            steps       <= steps - 2'd1;
            if (steps == 2'd1)
              state <= sdram_cmd_pkg::IDLE;  // last command of the series
            if (ser[0] == sdram_cmd_pkg::ACTV)
              page_active <= 1'b1;
            if (ser[0] == sdram_cmd_pkg::PRCH)
              page_active <= 1'b0;
          end
        end
        default:
          state <= sdram_cmd_pkg::IDLE;
      endcase
    end
  end

  // payload, qualified by pop and page_active
  always_ff @(posedge CLK)
  begin
    if (pop)
      req_q <= head;
    if (issue && (ser[0] == sdram_cmd_pkg::ACTV))
    begin
      open_row  <= req_row;
      open_bank <= req_bank;
    end
  end

endmodule

/* rtl/sdram_ctrl_top.sv */
`timescale 1ns/1ps

module sdram_ctrl_top
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     push,
  input  host_req_pkg::host_req_t  req,
  output logic                     full,
  input  logic                     ref_toggle,
  output sdram_cmd_pkg::cmd_word_t cmd,
  output logic                     cmd_latched,
  output logic                     page_active
);

  host_req_pkg::host_req_t head;
  logic                    has_req;
  logic                    pop;
  logic                    issue;
  logic                    ready;
  sdram_cmd_pkg::cmd_op_t  next_op;

  req_fifo req_fifo_i
  (
    .CLK     (CLK),
    .RST     (RST),
    .push    (push),
    .req     (req),
    .pop     (pop),
    .full    (full),
    .has_req (has_req),
    .head    (head)
  );

  cmd_sequencer cmd_sequencer_i
  (
    .CLK         (CLK),
    .RST         (RST),
    .has_req     (has_req),
    .head        (head),
    .ref_toggle  (ref_toggle),
    .ready       (ready),
    .pop         (pop),
    .next_op     (next_op),
    .issue       (issue),
    .cmd         (cmd),
    .cmd_latched (cmd_latched),
    .page_active (page_active)
  );

  bank_timer bank_timer_i
  (
    .CLK   (CLK),
    .RST   (RST),
    .issue (issue),
    .op    (next_op),  // pending command sets the bypass
    .ready (ready)
  );

endmodule

/* dv/sdram_ctrl_chk.sv */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_ctrl_chk
(
  input logic                       CLK,
  input logic                       RST,
  input sdram_cmd_pkg::cmd_word_t   cmd,
  input logic                       cmd_latched,
  input sdram_cmd_pkg::seq_state_t  state
);

  sdram_cmd_pkg::cmd_op_t prev_op;    // last command seen on the pins
  logic [4:0]             since;      // cycles since that command
  logic [4:0]             prev_gap;
  logic                   rw_repeat;

  always_comb
  begin
    case (prev_op)
      sdram_cmd_pkg::ACTV: prev_gap = 5'(`SDRAM_GAP_ACTV);
      sdram_cmd_pkg::ARSR: prev_gap = 5'(`SDRAM_GAP_ARSR);
      default:             prev_gap = 5'(`SDRAM_GAP_DEFAULT);
    endcase
  end

  assign rw_repeat = (cmd.op == prev_op) &&
                     ((prev_op == sdram_cmd_pkg::READ) || (prev_op == sdram_cmd_pkg::WRTE));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      prev_op <= sdram_cmd_pkg::NOOP;
      since   <= '0;
    end
    else if (cmd.op != sdram_cmd_pkg::NOOP)
    begin
      prev_op <= cmd.op;
      since   <= 5'd1;
    end
    else if (since != '1)
    begin
      since <= since + 5'd1;  // saturates
    end
  end

  a_spacing: assert property (@(posedge CLK) disable iff (!RST)
    ((cmd.op != sdram_cmd_pkg::NOOP) && (prev_op != sdram_cmd_pkg::NOOP))
      |-> ((since >= prev_gap) || rw_repeat))
    else $error("command issued before the gap of the previous one elapsed");

  a_latched: assert property (@(posedge CLK) disable iff (!RST)
    cmd_latched |-> ((cmd.op == sdram_cmd_pkg::READ) || (cmd.op == sdram_cmd_pkg::WRTE)))
    else $error("cmd_latched without a read or write on cmd");

  a_reset: assert property (@(posedge CLK)
    !RST |=> ((cmd.op == sdram_cmd_pkg::NOOP) && (state == sdram_cmd_pkg::IDLE)))
    else $error("reset did not leave cmd idle");

endmodule

/* dv/sdram_ctrl_tb.sv */
`timescale 1ns/1ps
`include "sdram_config.svh"

module sdram_ctrl_tb;

  localparam int PHASES    = 6;
  localparam int CYC_LIMIT = 400 * PHASES;  // 400 cycles per test phase
  localparam int BANK_LSB  = `SDRAM_COL_W;
  localparam int ROW_LSB   = `SDRAM_COL_W + `SDRAM_BANK_W;

  logic                     CLK;
  logic                     RST;
  logic                     push;
  host_req_pkg::host_req_t  req;
  logic                     full;
  logic                     ref_toggle;
  sdram_cmd_pkg::cmd_word_t cmd;
  logic                     cmd_latched;
  logic                     page_active;

  sdram_cmd_pkg::cmd_word_t exp_q[$];   // expected words, oldest first
  logic                     m_page;     // model of the open page
  sdram_cmd_pkg::row_t      m_row;
  sdram_cmd_pkg::bank_t     m_bank;
  int                       cycles = 0;
  integer                   seed;

  sdram_ctrl_top dut_i
  (
    .CLK         (CLK),
    .RST         (RST),
    .push        (push),
    .req         (req),
    .full        (full),
    .ref_toggle  (ref_toggle),
    .cmd         (cmd),
    .cmd_latched (cmd_latched),
    .page_active (page_active)
  );

  bind cmd_sequencer sdram_ctrl_chk chk_i
  (
    .CLK         (CLK),
    .RST         (RST),
    .cmd         (cmd),
    .cmd_latched (cmd_latched),
    .state       (state)
  );

  initial
  begin
    CLK = 1'b0;
    forever
      #50 CLK = ~CLK;  // 100 ns period
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= CYC_LIMIT)
      report_failure($sformatf("timeout: the run did not finish within %0d cycles", CYC_LIMIT));
  end

  function automatic host_req_pkg::host_req_t make_req(input sdram_cmd_pkg::row_t row,
                                                       input sdram_cmd_pkg::bank_t bank,
                                                       input logic [`SDRAM_COL_W-1:0] col,
                                                       input logic we);
    host_req_pkg::host_req_t r;
    r.addr = {row, bank, col};
    r.we   = we;
    return r;
  endfunction

  // reference model, appends the expected series and tracks the open page
  function automatic void expand_series(input logic is_ref, input host_req_pkg::host_req_t r);
    sdram_cmd_pkg::cmd_word_t w;
    sdram_cmd_pkg::row_t      row;
    sdram_cmd_pkg::bank_t     bank;
    row  = r.addr[ROW_LSB +: `SDRAM_ROW_W];
    bank = r.addr[BANK_LSB +: `SDRAM_BANK_W];
    w    = '0;
    if (is_ref)
    begin
      w.op   = sdram_cmd_pkg::PRCH;
      w.addr = 13'h0400;  // all banks
      exp_q.push_back(w);
      w.op   = sdram_cmd_pkg::ARSR;
      w.addr = '0;
      exp_q.push_back(w);
      m_page = 1'b0;
    end
    else
    begin
      if (!(m_page && (row == m_row) && (bank == m_bank)))
      begin
        w.op   = sdram_cmd_pkg::PRCH;
        w.addr = 13'h0400;
        exp_q.push_back(w);
        w.op   = sdram_cmd_pkg::ACTV;
        w.bank = bank;
        w.addr = {row[11:10], 1'b0, row[9:0]};
        exp_q.push_back(w);
        m_page = 1'b1;
        m_row  = row;
        m_bank = bank;
      end
      w.op   = r.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
      w.bank = bank;
      w.addr = r.addr[`SDRAM_COL_W-1:0];
      exp_q.push_back(w);
    end
  endfunction

  task automatic step();
    @(posedge CLK);
    #5;
  endtask

  // one-cycle push, the model keeps only what the queue accepts
  task automatic push_req(input host_req_pkg::host_req_t r, output logic taken);
    taken = !full;
    push  = 1'b1;
    req   = r;
    if (taken)
      expand_series(1'b0, r);
    step();
    push = 1'b0;
  endtask

  task automatic wait_drained();
    do
      step();
    while (exp_q.size() != 0);
  endtask

  // sequencer is idle and the queue empty, so the refresh goes next
  task automatic refresh_now();
    wait_drained();
    ref_toggle = !ref_toggle;
    expand_series(1'b1, '0);
    step();
  endtask

  initial
  begin : compare
    sdram_cmd_pkg::cmd_word_t want;
    logic                     lat_exp;
    forever
    begin
      @(negedge CLK);
      if (RST)
      begin
        lat_exp = 1'b0;
        if (cmd.op != sdram_cmd_pkg::NOOP)
        begin
          assert (exp_q.size() != 0)
            else report_failure("a command was issued when none was expected");
          want = exp_q.pop_front();
          assert (cmd === want)
            else report_failure($sformatf("Error at %0t ns: cmd = %h, expected %h",
                                          $time, cmd, want));
          lat_exp = (want.op == sdram_cmd_pkg::READ) || (want.op == sdram_cmd_pkg::WRTE);
          if (cmd.op == sdram_cmd_pkg::ACTV)
            assert (page_active === 1'b1)
              else report_failure($sformatf("Error at %0t ns: page_active = %b, expected 1",
                                            $time, page_active));
          if ((cmd.op == sdram_cmd_pkg::PRCH) || (cmd.op == sdram_cmd_pkg::ARSR))
            assert (page_active === 1'b0)
              else report_failure($sformatf("Error at %0t ns: page_active = %b, expected 0",
                                            $time, page_active));
        end
        assert (cmd_latched === lat_exp)
          else report_failure($sformatf("Error at %0t ns: cmd_latched = %b, expected %b",
                                        $time, cmd_latched, lat_exp));
      end
    end
  end

  initial
  begin : stimulus
    logic                 taken;
    logic [31:0]          rnd;
    sdram_cmd_pkg::row_t  row;
    sdram_cmd_pkg::bank_t bank;

    seed       = 8714;
    m_page     = 1'b0;
    m_row      = '0;
    m_bank     = '0;
    RST        = 1'b0;
    push       = 1'b0;
    req        = '0;
    ref_toggle = 1'b0;
    repeat (10)
      @(posedge CLK);
    #5;
    RST = 1'b1;
    step();

    push_req(make_req(12'h0A5, 2'd1, 13'h0123, 1'b0), taken);  // miss
    wait_drained();
    assert (page_active) else report_failure("page_active is low after the ACTV");
    push_req(make_req(12'h0A5, 2'd1, 13'h0456, 1'b0), taken);  // hit
    wait_drained();

    push_req(make_req(12'h0A5, 2'd1, 13'h0010, 1'b1), taken);
    push_req(make_req(12'h0A5, 2'd1, 13'h0011, 1'b1), taken);  // back to back writes
    wait_drained();

    push_req(make_req(12'hC07, 2'd1, 13'h1FFF, 1'b0), taken);  // new row
    wait_drained();
    push_req(make_req(12'hC07, 2'd2, 13'h0042, 1'b1), taken);  // new bank
    wait_drained();

    refresh_now();
    wait_drained();
    assert (!page_active) else report_failure("page_active is still high after a refresh");
    push_req(make_req(12'hC07, 2'd2, 13'h0043, 1'b0), taken);  // miss again
    wait_drained();

    // request already queued when the toggle lands
    expand_series(1'b1, '0);  // refresh goes ahead of it
    push_req(make_req(12'h0A5, 2'd3, 13'h0077, 1'b1), taken);
    ref_toggle = !ref_toggle;
    step();
    wait_drained();

    refresh_now();
    for (int i = 0; i < 5; i++)
    begin
      push_req(make_req(12'(12'h3C0 + i), 2'(i), 13'(i), i[0]), taken);
      if (i == 4)
        assert (!taken) else report_failure("the queue did not report full on the fifth push");
    end
    wait_drained();

    row  = 12'h0A5;
    bank = 2'd0;
    for (int n = 0; n < 200; n++)
    begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'd0)
        refresh_now();
      else
      begin
        if (rnd[4])  // else stay on the last page
        begin
          row  = rnd[5] ? 12'hC07 : 12'h0A5;
          bank = {1'b0, rnd[6]};
        end
        while (full)
          step();
        push_req(make_req(row, bank, rnd[31:19], rnd[7]), taken);
        if (rnd[8])
          step();  // idle gap
      end
    end
    wait_drained();
    repeat (8)
      step();

    $display("all tests passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
rtl/sdram_cmd_pkg.sv
rtl/host_req_pkg.sv
rtl/req_fifo.sv
rtl/bank_timer.sv
rtl/cmd_sequencer.sv
rtl/sdram_ctrl_top.sv
dv/sdram_ctrl_chk.sv
dv/sdram_ctrl_tb.sv

/* Bender.yml */
package:
  name: sdram_ctrl

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/sdram_cmd_pkg.sv
      - rtl/host_req_pkg.sv
      - rtl/req_fifo.sv
      - rtl/bank_timer.sv
      - rtl/cmd_sequencer.sv
      - rtl/sdram_ctrl_top.sv
  - target: test
    files:
      - dv/sdram_ctrl_chk.sv
      - dv/sdram_ctrl_tb.sv
